/* fpu_unit.f */
src/fpu_pkg.sv
src/fpu_op_if.sv
src/fpu_ctrl.sv
src/fpu_noncomp_lane.sv
src/fpu_fflags_csr.sv
src/fpu_unit.sv
verif/fpu_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the FPU testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
    --top-module fpu_unit_tb \
    -f fpu_unit.f \
    -o fpu_unit_sim

./obj_dir/fpu_unit_sim | tee sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* verif/fpu_unit_testdata.txt */
// op warp tag mask rs1[0..3] rs2[0..3] exp[0..3] upd nv clr gap
// lane 0 first; op codes as in fpu_pkg
0 0 1 f 3f800000 bf800000 40000000 7fc00000 bf800000 3f800000 80000000 0 bf800000 3f800000 c0000000 7fc00000 0 0 0 1
1 1 2 f 3f800000 bf800000 40000000 7fc00000 bf800000 3f800000 80000000 0 3f800000 bf800000 40000000 ffc00000 0 0 0 1
2 2 3 f 3f800000 bf800000 bf800000 7f800001 bf800000 bf800000 3f800000 80000000 bf800000 3f800000 bf800000 ff800001 0 0 0 0
9 3 4 f 12345678 deadbeef 7f800001 0 ffffffff ffffffff ffffffff ffffffff 12345678 deadbeef 7f800001 0 0 0 0 0
a 0 5 f cafef00d 80000000 1 ffffffff 0 0 0 0 cafef00d 80000000 1 ffffffff 0 0 0 2
3 1 6 f 3f800000 80000000 7fc00000 7fc00000 40000000 0 c0000000 ffc00000 3f800000 80000000 c0000000 7fc00000 1 0 0 1
4 1 7 f 3f800000 0 40400000 bf800000 40000000 80000000 7fc00000 c0000000 40000000 0 40400000 bf800000 1 0 0 1
3 2 8 f 7f800001 3f800000 3f800000 3f800000 3f000000 3f000000 3f000000 3f000000 3f000000 3f000000 3f000000 3f000000 1 1 0 1
4 3 9 f 3f800000 c0000000 7f800001 0 bf800000 ff800001 7fc00000 7f800000 3f800000 c0000000 7fc00000 7f800000 1 1 0 1
5 0 a f 3f800000 0 7fc00000 3f800000 3f800000 80000000 7fc00000 40000000 1 1 0 0 1 0 0 1
5 2 b f 7f800001 3f800000 3f800000 3f800000 3f800000 3f800000 3f800000 3f800000 0 1 1 1 1 1 0 1
6 3 c f 7fc00000 3f800000 80000000 bf800000 3f800000 40000000 0 bf800000 0 1 0 0 1 1 0 1
7 1 d f 3f800000 80000000 c0000000 40000000 3f800000 0 bf800000 3f800000 1 1 1 0 1 0 0 1
7 0 e f 3f800000 3f800000 3f800000 ffc00000 3f800000 3f800000 3f800000 3f800000 1 1 1 0 1 1 0 1
8 2 f f ff800000 bf800000 80000001 80000000 0 0 0 0 1 2 4 8 0 0 0 0
8 3 0 f 0 1 3f800000 7f800000 0 0 0 0 10 20 40 80 0 0 0 0
8 0 1 f 7f800001 7fc00000 ffffffff ff800001 0 0 0 0 100 200 200 100 0 0 0 1
3 1 2 5 3f800000 7f800001 40000000 7f800001 40000000 7f800001 3f800000 0 3f800000 0 3f800000 0 1 0 0 1
6 2 3 a 7f800001 3f800000 7fc00000 3f800000 0 40000000 0 3f000000 0 1 0 0 1 0 0 1
0 3 4 0 3f800000 3f800000 3f800000 3f800000 0 0 0 0 0 0 0 0 0 0 0 0
3 1 5 f 7f800001 0 0 0 3f800000 0 0 0 3f800000 0 0 0 1 1 0 0
0 2 6 f 3f800000 3f800000 3f800000 3f800000 0 0 0 0 3f800000 3f800000 3f800000 3f800000 0 0 1 0
5 0 7 f 0 0 0 0 0 0 0 0 1 1 1 1 1 0 1 0
7 3 8 f 7fc00000 0 0 0 0 0 0 0 0 1 1 1 1 1 1 0
4 1 9 f 0 0 0 0 3f800000 3f800000 3f800000 3f800000 3f800000 3f800000 3f800000 3f800000 1 0 0 0
6 2 a f 7f800001 0 0 0 3f800000 3f800000 3f800000 3f800000 0 1 1 1 1 1 0 3

/* verif/fpu_unit_tb.sv */
`default_nettype none

module fpu_unit_tb import fpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WORDS = 20;   // Words per vector
    localparam int MAXV  = 64;
    localparam int NRAND = 8;

    typedef struct packed {
        logic [31:0]  id;
        logic [3:0]   op;
        logic [1:0]   warp;
        logic [3:0]   tag;
        logic [127:0] data;
        logic         upd;
        logic         nv;
        logic         clr;
        logic [31:0]  issue;
    } exp_t;

    logic                 clk;
    logic                 rst_n_i;
    logic                 req_valid_i;
    logic [1:0]           req_warp_i;
    issue_tag_t           req_tag_i;
    fpu_op_e              req_op_i;
    logic [3:0]           req_mask_i;
    logic [127:0]         req_rs1_i;
    logic [127:0]         req_rs2_i;
    logic                 cmt_valid_o;
    logic [1:0]           cmt_warp_o;
    issue_tag_t           cmt_tag_o;
    logic [127:0]         cmt_data_o;
    logic                 cmt_upd_fflags_o;
    fflags_t              cmt_fflags_o;
    logic [1:0]           fflags_rd_warp_i;
    logic                 fflags_clr_i;
    fflags_t              fflags_rd_o;

    logic [31:0] tv [0:WORDS*MAXV-1];
    exp_t        exp_q [$];
    exp_t        cur;
    exp_t        pend;
    logic        pend_vld;
    fflags_t     model [4];
    logic [31:0] cycle_cnt;
    logic [31:0] limit;
    logic        test_err;
    int          err_cnt;
    int          pass_cnt;
    int          fail_cnt;

    fpu_unit #(.NUM_LANES(4), .NUM_WARPS(4)) dut (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .req_valid_i      (req_valid_i),
        .req_warp_i       (req_warp_i),
        .req_tag_i        (req_tag_i),
        .req_op_i         (req_op_i),
        .req_mask_i       (req_mask_i),
        .req_rs1_i        (req_rs1_i),
        .req_rs2_i        (req_rs2_i),
        .cmt_valid_o      (cmt_valid_o),
        .cmt_warp_o       (cmt_warp_o),
        .cmt_tag_o        (cmt_tag_o),
        .cmt_data_o       (cmt_data_o),
        .cmt_upd_fflags_o (cmt_upd_fflags_o),
        .cmt_fflags_o     (cmt_fflags_o),
        .fflags_rd_warp_i (fflags_rd_warp_i),
        .fflags_clr_i     (fflags_clr_i),
        .fflags_rd_o      (fflags_rd_o)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got %0h exp %0h", name, got, exp);
            test_err = 1'b1;
            err_cnt++;
        end
    endtask

    task automatic tally(input string what);
        if (test_err) begin
            fail_cnt++;
            $display("%s: failed", what);
        end else begin
            pass_cnt++;
            $display("%s: ok", what);
        end
    endtask

    task automatic issue(input exp_t e, input logic [3:0] mask,
                         input logic [127:0] rs1, input logic [127:0] rs2);
        exp_t t;
        @(negedge clk);
        t           = e;
        t.issue     = cycle_cnt + 1;  // Sampled at the next rising edge
        req_valid_i = 1'b1;
        req_op_i    = fpu_op_e'(e.op);
        req_warp_i  = e.warp;
        req_tag_i   = e.tag;
        req_mask_i  = mask;
        req_rs1_i   = rs1;
        req_rs2_i   = rs2;
        exp_q.push_back(t);
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (limit != 0 && cycle_cnt > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("** FAIL **");
            $finish;
        end
    end

    // Commit monitor and flags model
    always @(negedge clk) begin
        if (rst_n_i) begin
            fflags_clr_i = 1'b0;
            if (pend_vld) begin
                check("fflags_rd_o", 128'(fflags_rd_o), 128'(model[pend.warp]));
                tally($sformatf("test %0d op %0d tag %0h", pend.id, pend.op, pend.tag));
                pend_vld = 1'b0;
            end
            if (cmt_valid_o) begin
                test_err = 1'b0;
                if (exp_q.size() == 0) begin
                    $display("A commit arrived with no request outstanding");
                    fail_cnt++;
                end else begin
                    cur = exp_q.pop_front();
                    check("cmt_data_o", cmt_data_o, cur.data);
                    check("cmt_warp_o", 128'(cmt_warp_o), 128'(cur.warp));
                    check("cmt_tag_o", 128'(cmt_tag_o), 128'(cur.tag));
                    check("cmt_upd_fflags_o", 128'(cmt_upd_fflags_o), 128'(cur.upd));
                    check("cmt_fflags_o", 128'(cmt_fflags_o), 128'({cur.nv, 4'b0}));
                    check("commit_delay", 128'(cycle_cnt - cur.issue), 128'd2);
                    if (cur.clr) begin
                        model[cur.warp] = cur.upd ? {cur.nv, 4'b0} : 5'b0;
                    end else if (cur.upd) begin
                        model[cur.warp] = model[cur.warp] | {cur.nv, 4'b0};
                    end
                    fflags_rd_warp_i = cur.warp;
                    fflags_clr_i     = cur.clr;
                    pend             = cur;
                    pend_vld         = 1'b1;
                end
            end
        end
    end

    initial begin
        int          nvec;
        int          maxgap;
        int          b;
        logic [31:0] seed;
        logic [31:0] a;
        logic [31:0] c;
        logic [127:0] rs1;
        logic [127:0] rs2;
        logic [127:0] res;
        exp_t        e;

        clk              = 1'b0;
        rst_n_i          = 1'b0;
        req_valid_i      = 1'b0;
        req_warp_i       = '0;
        req_tag_i        = '0;
        req_op_i         = OP_SGNJ;
        req_mask_i       = '0;
        req_rs1_i        = '0;
        req_rs2_i        = '0;
        fflags_rd_warp_i = '0;
        fflags_clr_i     = 1'b0;
        cycle_cnt        = '0;
        limit            = '0;
        pend_vld         = 1'b0;
        test_err         = 1'b0;
        err_cnt          = 0;
        pass_cnt         = 0;
        fail_cnt         = 0;
        for (int w = 0; w < 4; w++) begin
            model[w] = '0;
        end
        for (int i = 0; i < WORDS*MAXV; i++) begin
            tv[i] = '1;  // Unused entries end the vector list
        end
        $readmemh("verif/fpu_unit_testdata.txt", tv);

        nvec   = 0;
        maxgap = 0;
        while (nvec < MAXV && tv[nvec*WORDS] != 32'hffffffff) begin
            if (int'(tv[nvec*WORDS+19]) > maxgap) begin
                maxgap = int'(tv[nvec*WORDS+19]);
            end
            nvec++;
        end
        limit = (nvec + NRAND) * (maxgap + 4) + 100;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        test_err = 1'b0;
        check("cmt_valid_o", 128'(cmt_valid_o), 128'd0);
        tally("reset");

        for (int v = 0; v < nvec; v++) begin
            b      = v * WORDS;
            e      = '0;
            e.id   = v;
            e.op   = tv[b][3:0];
            e.warp = tv[b+1][1:0];
            e.tag  = tv[b+2][3:0];
            e.data = {tv[b+15], tv[b+14], tv[b+13], tv[b+12]};
            e.upd  = tv[b+16][0];
            e.nv   = tv[b+17][0];
            e.clr  = tv[b+18][0];
            issue(e, tv[b+3][3:0], {tv[b+7], tv[b+6], tv[b+5], tv[b+4]},
                  {tv[b+11], tv[b+10], tv[b+9], tv[b+8]});
            repeat (tv[b+19]) begin
                @(negedge clk);
                req_valid_i = 1'b0;
            end
        end

        // Random SGNJ and SGNJX filler, back to back
        seed = 32'hc80b;
        for (int r = 0; r < NRAND; r++) begin
            seed = xorshift(seed);
            c    = seed;
            for (int l = 0; l < 4; l++) begin
                seed = xorshift(seed);
                a    = seed;
                seed = xorshift(seed);
                rs1[32*l +: 32] = a;
                rs2[32*l +: 32] = seed;
                if (c[0]) begin
                    res[32*l +: 32] = {a[31] ^ seed[31], a[30:0]};
                end else begin
                    res[32*l +: 32] = {seed[31], a[30:0]};
                end
            end
            e      = '0;
            e.id   = nvec + r;
            e.op   = c[0] ? 4'(OP_SGNJX) : 4'(OP_SGNJ);
            e.warp = c[2:1];
            e.tag  = c[7:4];
            e.data = res;
            issue(e, 4'hf, rs1, rs2);
        end
        @(negedge clk);
        req_valid_i = 1'b0;

        repeat (20) begin
            if (exp_q.size() != 0 || pend_vld) begin
                @(negedge clk);
            end
        end
        if (exp_q.size() != 0) begin
            $display("%0d requests never committed", exp_q.size());
            fail_cnt++;
        end

        $display("tests passed %0d, failed %0d, mismatches %0d", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/fpu_unit.sv */
`default_nettype none

module fpu_unit import fpu_pkg::*; #(
    parameter int  NUM_LANES = 4,
    parameter int  NUM_WARPS = 4,
    localparam int WARP_W    = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  wire                         clk,
    input  wire                         rst_n_i,

    input  wire                         req_valid_i,
    input  wire [WARP_W-1:0]            req_warp_i,
    input  wire issue_tag_t             req_tag_i,
    input  wire fpu_op_e                req_op_i,
    input  wire [NUM_LANES-1:0]         req_mask_i,
    input  wire fp32_t [NUM_LANES-1:0]  req_rs1_i,
    input  wire fp32_t [NUM_LANES-1:0]  req_rs2_i,

    output logic                        cmt_valid_o,
    output logic [WARP_W-1:0]           cmt_warp_o,
    output issue_tag_t                  cmt_tag_o,
    output fp32_t [NUM_LANES-1:0]       cmt_data_o,
    output logic                        cmt_upd_fflags_o,
    output fflags_t                     cmt_fflags_o,

    input  wire [WARP_W-1:0]            fflags_rd_warp_i,
    input  wire                         fflags_clr_i,
    output fflags_t                     fflags_rd_o
);

    fp32_t [NUM_LANES-1:0] lane_result;
    logic [NUM_LANES-1:0]  lane_nv;
    logic                  upd_valid;
    logic [WARP_W-1:0]     upd_warp;
    fflags_t               upd_flags;

    fpu_op_if #(.NUM_LANES(NUM_LANES)) op_if ();

    fpu_ctrl #(
        .NUM_LANES (NUM_LANES),
        .NUM_WARPS (NUM_WARPS)
    ) u_ctrl (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .req_valid_i      (req_valid_i),
        .req_warp_i       (req_warp_i),
        .req_tag_i        (req_tag_i),
        .req_op_i         (req_op_i),
        .req_mask_i       (req_mask_i),
        .req_rs1_i        (req_rs1_i),
        .req_rs2_i        (req_rs2_i),
        .op_if            (op_if.ctrl_mp),
        .lane_result_i    (lane_result),
        .lane_nv_i        (lane_nv),
        .cmt_valid_o      (cmt_valid_o),
        .cmt_warp_o       (cmt_warp_o),
        .cmt_tag_o        (cmt_tag_o),
        .cmt_data_o       (cmt_data_o),
        .cmt_upd_fflags_o (cmt_upd_fflags_o),
        .cmt_fflags_o     (cmt_fflags_o),
        .upd_valid_o      (upd_valid),
        .upd_warp_o       (upd_warp),
        .upd_flags_o      (upd_flags)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        fpu_noncomp_lane #(.LANE(g)) u_lane (
            .clk      (clk),
            .rst_n_i  (rst_n_i),
            .op_if    (op_if.lane_mp),
            .result_o (lane_result[g]),
            .nv_o     (lane_nv[g])
        );
    end

    fpu_fflags_csr #(.NUM_WARPS(NUM_WARPS)) u_fflags (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .upd_valid_i (upd_valid),
        .upd_warp_i  (upd_warp),
        .upd_flags_i (upd_flags),
        .rd_warp_i   (fflags_rd_warp_i),
        .clr_i       (fflags_clr_i),
        .rd_flags_o  (fflags_rd_o)
    );

endmodule

`default_nettype wire

/* src/fpu_fflags_csr.sv */
`default_nettype none

module fpu_fflags_csr import fpu_pkg::*; #(
    parameter int  NUM_WARPS = 4,
    localparam int WARP_W    = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  wire               clk,
    input  wire               rst_n_i,
    input  wire               upd_valid_i,
    input  wire [WARP_W-1:0]  upd_warp_i,
    input  wire fflags_t      upd_flags_i,
    input  wire [WARP_W-1:0]  rd_warp_i,
    input  wire               clr_i,
    output fflags_t           rd_flags_o
);

    fflags_t              flags_q [NUM_WARPS];
    logic [NUM_WARPS-1:0] upd_hit;
    logic [NUM_WARPS-1:0] clr_hit;

    always_comb begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            upd_hit[w] = upd_valid_i & (upd_warp_i == WARP_W'(w));
            clr_hit[w] = clr_i & (rd_warp_i == WARP_W'(w));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int w = 0; w < NUM_WARPS; w++) begin
                flags_q[w] <= '0;
            end
        end else begin
            for (int w = 0; w < NUM_WARPS; w++) begin
                if (clr_hit[w]) begin
                    flags_q[w] <= upd_hit[w] ? upd_flags_i : '0;  // Update survives clear
                end else if (upd_hit[w]) begin
                    flags_q[w] <= flags_q[w] | upd_flags_i;      // Accrue
                end
            end
        end
    end

    assign rd_flags_o = flags_q[rd_warp_i];

endmodule

`default_nettype wire

/* src/fpu_noncomp_lane.sv */
`default_nettype none

module fpu_noncomp_lane import fpu_pkg::*; #(
    parameter int LANE = 0
) (
    input  wire        clk,
    input  wire        rst_n_i,
    fpu_op_if.lane_mp  op_if,
    output fp32_t      result_o,
    output logic       nv_o
);

    fp32_t       a;
    fp32_t       b;
    logic [9:0]  a_cls;
    logic [9:0]  b_cls;
    logic        a_nan;
    logic        b_nan;
    logic        a_snan;
    logic        b_snan;
    logic        any_nan;
    logic        both_zero;
    logic        a_lt_b;
    logic        a_eq_b;
    fp32_t       res;
    logic        nv;

    // One-hot RISC-V class, bit 0 is -inf
    function automatic logic [9:0] fp_class(input fp32_t x);
        logic [7:0]  e;
        logic [22:0] m;
        logic [9:0]  c;
        e = x[30:23];
        m = x[22:0];
        c = '0;
        if (e == 8'hff) begin
            if (m == '0) begin
                c[x[31] ? 0 : 7] = 1'b1;
            end else begin
                c[m[22] ? 9 : 8] = 1'b1;  // Quiet bit set means qNaN
            end
        end else if (e == 8'h00) begin
            if (m == '0) begin
                c[x[31] ? 3 : 4] = 1'b1;
            end else begin
                c[x[31] ? 2 : 5] = 1'b1;
            end
        end else begin
            c[x[31] ? 1 : 6] = 1'b1;
        end
        return c;
    endfunction

    assign a = op_if.rs1[LANE];
    assign b = op_if.rs2[LANE];

    assign a_cls     = fp_class(a);
    assign b_cls     = fp_class(b);
    assign a_snan    = a_cls[8];
    assign b_snan    = b_cls[8];
    assign a_nan     = |a_cls[9:8];
    assign b_nan     = |b_cls[9:8];
    assign any_nan   = a_nan | b_nan;
    assign both_zero = (|a_cls[4:3]) & (|b_cls[4:3]);

    // Total order on non-NaN values, -0 below +0
    always_comb begin
        if (a[31] != b[31]) begin
            a_lt_b = a[31];
        end else if (a[31]) begin
            a_lt_b = a[30:0] > b[30:0];
        end else begin
            a_lt_b = a[30:0] < b[30:0];
        end
    end

    assign a_eq_b = (a == b) | both_zero;

    always_comb begin
        res = a;
        nv  = 1'b0;
        unique case (op_if.op)
            OP_SGNJ:  res = {b[31], a[30:0]};
            OP_SGNJN: res = {~b[31], a[30:0]};
            OP_SGNJX: res = {a[31] ^ b[31], a[30:0]};
            OP_MIN, OP_MAX: begin
                nv = a_snan | b_snan;
                if (a_nan && b_nan) begin
                    res = CANON_NAN;
                end else if (a_nan) begin
                    res = b;
                end else if (b_nan) begin
                    res = a;
                end else begin
                    res = ((op_if.op == OP_MIN) == a_lt_b) ? a : b;
                end
            end
            OP_FEQ: begin
                nv  = a_snan | b_snan;  // Quiet compare
                res = {31'b0, ~any_nan & a_eq_b};
            end
            OP_FLT: begin
                nv  = any_nan;
                res = {31'b0, ~any_nan & a_lt_b & ~both_zero};
            end
            OP_FLE: begin
                nv  = any_nan;
                res = {31'b0, ~any_nan & (a_lt_b | a_eq_b)};
            end
            OP_CLASS:         res = {22'b0, a_cls};
            OP_MVXW, OP_MVWX: res = a;  // Raw bit move
            default:          res = a;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            nv_o <= 1'b0;
        end else if (op_if.valid) begin
            nv_o <= nv;
        end
    end

    always_ff @(posedge clk) begin
        if (op_if.valid) begin
            result_o <= res;
        end
    end

endmodule

`default_nettype wire

/* src/fpu_ctrl.sv */
`default_nettype none

module fpu_ctrl import fpu_pkg::*; #(
    parameter int  NUM_LANES = 4,
    parameter int  NUM_WARPS = 4,
    localparam int WARP_W    = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  wire                         clk,
    input  wire                         rst_n_i,

    input  wire                         req_valid_i,
    input  wire [WARP_W-1:0]            req_warp_i,
    input  wire issue_tag_t             req_tag_i,
    input  wire fpu_op_e                req_op_i,
    input  wire [NUM_LANES-1:0]         req_mask_i,
    input  wire fp32_t [NUM_LANES-1:0]  req_rs1_i,
    input  wire fp32_t [NUM_LANES-1:0]  req_rs2_i,

    fpu_op_if.ctrl_mp                   op_if,
    input  wire fp32_t [NUM_LANES-1:0]  lane_result_i,
    input  wire [NUM_LANES-1:0]         lane_nv_i,

    output logic                        cmt_valid_o,
    output logic [WARP_W-1:0]           cmt_warp_o,
    output issue_tag_t                  cmt_tag_o,
    output fp32_t [NUM_LANES-1:0]       cmt_data_o,
    output logic                        cmt_upd_fflags_o,
    output fflags_t                     cmt_fflags_o,

    output logic                        upd_valid_o,
    output logic [WARP_W-1:0]           upd_warp_o,
    output fflags_t                     upd_flags_o
);

    logic [WARP_W-1:0]     s1_warp;
    issue_tag_t            s1_tag;

    logic                  s2_valid;
    logic [WARP_W-1:0]     s2_warp;
    issue_tag_t            s2_tag;
    fpu_op_e               s2_op;
    logic [NUM_LANES-1:0]  s2_mask;

    fp32_t [NUM_LANES-1:0] cmt_data_d;
    logic                  cmt_nv_d;
    logic                  cmt_upd_d;
    fflags_t               cmt_fflags_d;

    // Stage one, request register driving the lanes
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            op_if.valid <= 1'b0;
        end else begin
            op_if.valid <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            op_if.op        <= req_op_i;
            op_if.lane_mask <= req_mask_i;
            op_if.rs1       <= req_rs1_i;
            op_if.rs2       <= req_rs2_i;
            s1_warp         <= req_warp_i;
            s1_tag          <= req_tag_i;
        end
    end

    // Stage two, aligned with the lane result registers
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= op_if.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (op_if.valid) begin
            s2_warp <= s1_warp;
            s2_tag  <= s1_tag;
            s2_op   <= op_if.op;
            s2_mask <= op_if.lane_mask;
        end
    end

    always_comb begin
        cmt_nv_d = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            cmt_data_d[i] = s2_mask[i] ? lane_result_i[i] : '0;  // Inactive lanes read zero
            cmt_nv_d      = cmt_nv_d | (s2_mask[i] & lane_nv_i[i]);
        end
    end

    always_comb begin
        cmt_fflags_d              = '0;
        cmt_fflags_d[FLAG_NV_BIT] = cmt_nv_d;  // Only NV can occur here
    end

    assign cmt_upd_d = s2_op inside {OP_MIN, OP_MAX, OP_FEQ, OP_FLT, OP_FLE};

    // Commit register
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cmt_valid_o <= 1'b0;
        end else begin
            cmt_valid_o <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s2_valid) begin
            cmt_warp_o       <= s2_warp;
            cmt_tag_o        <= s2_tag;
            cmt_data_o       <= cmt_data_d;
            cmt_upd_fflags_o <= cmt_upd_d;
            cmt_fflags_o     <= cmt_fflags_d;
        end
    end

    assign upd_valid_o = cmt_valid_o & cmt_upd_fflags_o;
    assign upd_warp_o  = cmt_warp_o;
    assign upd_flags_o = cmt_fflags_o;

endmodule

`default_nettype wire

/* src/fpu_op_if.sv */
`default_nettype none

// Decoded request, stage one to every lane
interface fpu_op_if import fpu_pkg::*; #(
    parameter int NUM_LANES = 4
);

    logic                  valid;
    fpu_op_e               op;
    logic [NUM_LANES-1:0]  lane_mask;
    fp32_t [NUM_LANES-1:0] rs1;
    fp32_t [NUM_LANES-1:0] rs2;

    modport ctrl_mp (
        output valid,
        output op,
        output lane_mask,
        output rs1,
        output rs2
    );

    modport lane_mp (
        input valid,
        input op,
        input lane_mask,
        input rs1,
        input rs2
    );

endinterface

`default_nettype wire

/* src/fpu_pkg.sv */
`default_nettype none

package fpu_pkg;

    typedef logic [31:0] fp32_t;       // One lane operand or result
    typedef logic [4:0]  fflags_t;     // NV DZ OF UF NX
    typedef logic [3:0]  issue_tag_t;  // Issue queue tag

    typedef enum logic [3:0] {
        OP_SGNJ  = 4'd0,
        OP_SGNJN = 4'd1,
        OP_SGNJX = 4'd2,
        OP_MIN   = 4'd3,
        OP_MAX   = 4'd4,
        OP_FEQ   = 4'd5,
        OP_FLT   = 4'd6,
        OP_FLE   = 4'd7,
        OP_CLASS = 4'd8,
        OP_MVXW  = 4'd9,   // Float reg to int reg
        OP_MVWX  = 4'd10   // Int reg to float reg
    } fpu_op_e;

    localparam fp32_t CANON_NAN   = 32'h7fc00000;  // Quiet NaN, positive, zero payload
    localparam int    FLAG_NV_BIT = 4;             // Invalid operation

endpackage

`default_nettype wire
